// File: bench/bus_memory_model.sv
`timescale 1ns/1ps

module bus_memory_model import core_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  addr_t addr,
  input  data_t wdata,
  output data_t rdata,
  input  logic  read_q,
  input  logic  write_q,
  output logic  read_dn,
  output logic  write_dn,
  input  logic  load_en,
  input  addr_t load_addr,
  input  data_t load_data,
  input  addr_t peek_addr,
  output data_t peek_data
);

  data_t       mem [256];
  logic        busy;
  int unsigned wait_cnt;
  integer      seed;

  initial seed = 32'hb03d;

  // back door for the testbench
  assign peek_data = mem[peek_addr];

  always @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
    if (rst) begin
      read_dn  <= 1'b0;
      write_dn <= 1'b0;
      busy     <= 1'b0;
      wait_cnt <= 0;
      rdata    <= '0;
    end else if (read_dn || write_dn) begin
      // done lasts one cycle and the request drops on this edge
      read_dn  <= 1'b0;
      write_dn <= 1'b0;
      busy     <= 1'b0;
    end else if (read_q || write_q) begin
      if (!busy) begin
        busy     <= 1'b1;
        wait_cnt <= $unsigned($random(seed)) % 4;
      end else if (wait_cnt == 0) begin
        if (read_q) begin
          read_dn <= 1'b1;
          rdata   <= mem[addr];
        end else begin
          write_dn  <= 1'b1;
          mem[addr] <= wdata;
        end
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

endmodule

// File: bench/tb_internal_bus.sv
`timescale 1ns/1ps

module tb_internal_bus import core_pkg::*; ();

  logic  clk;
  logic  rst;
  logic  start;
  addr_t base_addr;
  addr_t base_addr_data;
  addr_t addr_out;
  data_t data_out;
  data_t data_in;
  logic  read_q;
  logic  write_q;
  logic  read_dn;
  logic  write_dn;
  cmd_t  command;
  logic  halted;
  logic  load_en;
  addr_t load_addr;
  data_t load_data;
  addr_t peek_addr;
  data_t peek_data;

  data_t  img [256];
  data_t  ref_mem [256];
  cmd_t   alu_prog [$];
  cmd_t   jump_prog [$];
  addr_t  exp_addr [$];
  data_t  exp_data [$];
  cmd_t   ref_last_cmd;
  integer seed;
  int     main_errs = 0;
  int     main_checks = 0;
  int     cmp_errs = 0;
  int     cmp_checks = 0;
  int     bus_errs = 0;
  int     bus_checks = 0;
  int     wr_seen = 0;

  internal_bus i_dut (
    .clk(clk),
    .rst(rst),
    .start(start),
    .base_addr(base_addr),
    .base_addr_data(base_addr_data),
    .addr_out(addr_out),
    .data_out(data_out),
    .data_in(data_in),
    .read_q(read_q),
    .write_q(write_q),
    .read_dn(read_dn),
    .write_dn(write_dn),
    .command(command),
    .halted(halted)
  );

  bus_memory_model i_mem (
    .clk(clk),
    .rst(rst),
    .addr(addr_out),
    .wdata(data_out),
    .rdata(data_in),
    .read_q(read_q),
    .write_q(write_q),
    .read_dn(read_dn),
    .write_dn(write_dn),
    .load_en(load_en),
    .load_addr(load_addr),
    .load_data(load_data),
    .peek_addr(peek_addr),
    .peek_data(peek_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic cmd_t make_cmd(input logic [3:0] op, input addr_t dst, input addr_t s1,
                                    input addr_t s0);
    return {op, 4'h0, dst, s1, s0};
  endfunction

  function automatic addr_t rand_offset();
    return addr_t'($random(seed)) & 8'h3f;
  endfunction

  // runs the program on ref_mem, queues the expected writes, returns the command count
  function automatic int run_reference(input addr_t b_cmd, input addr_t b_data);
    addr_t      ptr;
    addr_t      dst;
    cmd_t       c;
    logic [3:0] op;
    data_t      a;
    data_t      b;
    data_t      r;
    int         steps;
    logic       stop;
    ptr = b_cmd;
    steps = 0;
    stop = 1'b0;
    c = '0;
    while (!stop && steps < 256) begin
      c = {ref_mem[ptr], ref_mem[ptr + 8'd1]};
      ptr = ptr + 8'd2;
      steps++;
      op = c[CMD_OP_HI:CMD_OP_LO];
      dst = b_data + c[CMD_DST_LO +: ADDR_W];
      a = ref_mem[b_data + c[CMD_S0_LO +: ADDR_W]];
      b = ref_mem[b_data + c[CMD_S1_LO +: ADDR_W]];
      if (op == OP_HALT) begin
        stop = 1'b1;
      end else if (op == OP_JMP) begin
        ptr = b_cmd + c[CMD_DST_LO +: ADDR_W];
      end else if (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_MOV}) begin
        case (op)
          OP_ADD:  r = a + b;
          OP_SUB:  r = a - b;
          OP_AND:  r = a & b;
          OP_OR:   r = a | b;
          OP_XOR:  r = a ^ b;
          default: r = a;
        endcase
        ref_mem[dst] = r;
        exp_addr.push_back(dst);
        exp_data.push_back(r);
      end
    end
    ref_last_cmd = c;
    return steps;
  endfunction

  task automatic fill_image();
    for (int i = 0; i < 256; i++) begin
      img[i] = (data_t'(i) * 16'h0101) ^ 16'h5ac3;
    end
  endtask

  // high half at the even address
  task automatic place_program(input cmd_t p[$], input addr_t b);
    for (int k = 0; k < p.size(); k++) begin
      img[addr_t'(int'(b) + 2 * k)] = p[k][31:16];
      img[addr_t'(int'(b) + 2 * k + 1)] = p[k][15:0];
    end
  endtask

  task automatic load_memory();
    for (int i = 0; i < 256; i++) begin
      @(posedge clk);
      load_en <= 1'b1;
      load_addr <= addr_t'(i);
      load_data <= img[i];
      ref_mem[i] = img[i];
    end
    @(posedge clk);
    load_en <= 1'b0;
  endtask

  task automatic check_word(input addr_t a, input data_t exp);
    @(posedge clk);
    peek_addr <= a;
    @(negedge clk);
    main_checks++;
    if (peek_data !== exp) begin
      $display("ERROR peek_data at %h expected %h got %h", a, exp, peek_data);
      main_errs++;
    end
  endtask

  task automatic run_and_check(input int tno, input addr_t b_cmd, input addr_t b_data);
    int steps;
    int cyc;
    steps = run_reference(b_cmd, b_data);
    @(posedge clk);
    base_addr <= b_cmd;
    base_addr_data <= b_data;
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    cyc = 0;
    @(negedge clk);
    while (!halted && cyc < steps * 40) begin
      @(negedge clk);
      cyc++;
    end
    if (!halted) begin
      $display("core never halted within %0d cycles in test %0d", steps * 40, tno);
      $display("CHECKS FAILED");
      $finish;
    end else begin
      main_checks++;
      if (wr_seen != exp_addr.size()) begin
        $display("core made %0d writes where %0d were expected", wr_seen, exp_addr.size());
        main_errs++;
      end
      if (command !== ref_last_cmd) begin
        $display("ERROR command expected %h got %h", ref_last_cmd, command);
        main_errs++;
      end
      for (int i = 0; i < 256; i++) begin
        check_word(addr_t'(i), ref_mem[i]);
      end
    end
  endtask

  task automatic report_test(input int tno, input string name, input int snap);
    $display("test %0d %s: %s", tno, name,
             (main_errs + cmp_errs + bus_errs == snap) ? "ok" : "failed");
  endtask

  // every finished write against the next reference write
  always @(negedge clk) begin
    if (!rst && write_q && write_dn) begin
      cmp_checks++;
      if (wr_seen >= exp_addr.size()) begin
        $display("write to %h with no matching reference write", addr_out);
        cmp_errs++;
      end else begin
        if (addr_out !== exp_addr[wr_seen]) begin
          $display("ERROR addr_out expected %h got %h", exp_addr[wr_seen], addr_out);
          cmp_errs++;
        end
        if (data_out !== exp_data[wr_seen]) begin
          $display("ERROR data_out expected %h got %h", exp_data[wr_seen], data_out);
          cmp_errs++;
        end
      end
      wr_seen++;
    end
  end

  // bus monitor
  logic  rd_wait = 1'b0;
  logic  wr_wait = 1'b0;
  addr_t held_addr = '0;

  always @(negedge clk) begin
    if (!rst) begin
      bus_checks++;
      if (read_q && write_q) begin
        $display("read_q and write_q high together at %0t", $time);
        bus_errs++;
      end
      if (rd_wait && (!read_q || addr_out !== held_addr)) begin
        $display("read request dropped or moved its address before read_dn at %0t", $time);
        bus_errs++;
      end
      if (wr_wait && (!write_q || addr_out !== held_addr)) begin
        $display("write request dropped or moved its address before write_dn at %0t", $time);
        bus_errs++;
      end
    end
    rd_wait = !rst && read_q && !read_dn;
    wr_wait = !rst && write_q && !write_dn;
    held_addr = addr_out;
  end

  initial begin
    int snap;
    rst = 1'b1;
    start = 1'b0;
    base_addr = '0;
    base_addr_data = '0;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    peek_addr = '0;
    seed = 32'hb03d;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    snap = main_errs;
    @(negedge clk);
    main_checks++;
    if (read_q !== 1'b0) begin
      $display("ERROR read_q expected 0 got %h", read_q);
      main_errs++;
    end
    if (write_q !== 1'b0) begin
      $display("ERROR write_q expected 0 got %h", write_q);
      main_errs++;
    end
    if (halted !== 1'b0) begin
      $display("ERROR halted expected 0 got %h", halted);
      main_errs++;
    end
    repeat (12) begin
      @(negedge clk);
      if (read_q || write_q) begin
        $display("memory request raised before start");
        main_errs++;
      end
    end
    report_test(1, "reset state", snap);

    // random alu ops on offsets below 0x40 and a final halt
    for (int k = 0; k < 12; k++) begin
      alu_prog.push_back(make_cmd(4'($unsigned($random(seed)) % 6), rand_offset(),
                                  rand_offset(), rand_offset()));
    end
    alu_prog.push_back(make_cmd(OP_HALT, 8'h00, 8'h00, 8'h00));
    snap = main_errs + cmp_errs + bus_errs;
    fill_image();
    place_program(alu_prog, 8'h00);
    load_memory();
    run_and_check(2, 8'h00, 8'h80);
    report_test(2, "alu program", snap);

    // jmp to command 3 skips the marker write to 0xa0
    jump_prog.push_back(make_cmd(OP_MOV, 8'h10, 8'h00, 8'h01));
    jump_prog.push_back(make_cmd(OP_JMP, 8'h06, 8'h00, 8'h00));
    jump_prog.push_back(make_cmd(OP_MOV, 8'h20, 8'h00, 8'h02));
    jump_prog.push_back(make_cmd(OP_ADD, 8'h11, 8'h02, 8'h01));
    jump_prog.push_back(make_cmd(OP_HALT, 8'h00, 8'h00, 8'h00));
    snap = main_errs + cmp_errs + bus_errs;
    fill_image();
    place_program(jump_prog, 8'h00);
    load_memory();
    run_and_check(3, 8'h00, 8'h80);
    check_word(8'ha0, img[8'ha0]);
    check_word(8'h91, img[8'h81] + img[8'h82]);
    report_test(3, "jump", snap);

    snap = main_errs + cmp_errs + bus_errs;
    fill_image();
    place_program(alu_prog, 8'h40);
    load_memory();
    run_and_check(4, 8'h40, 8'hc0);
    report_test(4, "base relocation", snap);

    // memory keeps the results of test 4
    snap = main_errs + cmp_errs + bus_errs;
    run_and_check(6, 8'h40, 8'hc0);
    report_test(6, "restart from halt", snap);

    $display("test 5 bus discipline: %s over %0d cycles", (bus_errs == 0) ? "ok" : "failed",
             bus_checks);
    snap = main_errs + cmp_errs + bus_errs;
    $display("checks %0d, errors %0d", main_checks + cmp_checks + bus_checks, snap);
    if (snap == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
design/core_pkg.sv
design/cmd_pointer.sv
design/state_sequencer.sv
design/bus_master.sv
design/alu.sv
design/internal_bus.sv
bench/bus_memory_model.sv
bench/tb_internal_bus.sv

// File: design/alu.sv
`timescale 1ns/1ps

module alu import core_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  state_t  state,
  input  opcode_t opcode,
  input  data_t   src0,
  input  data_t   src1,
  output data_t   result
);

  data_t op_value;

  // add and sub wrap at the word width
  always_comb begin
    case (opcode)
      OP_ADD:  op_value = src0 + src1;
      OP_SUB:  op_value = src0 - src1;
      OP_AND:  op_value = src0 & src1;
      OP_OR:   op_value = src0 | src1;
      OP_XOR:  op_value = src0 ^ src1;
      OP_MOV:  op_value = src0;
      default: op_value = result;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
    end else if (state == ST_EXECUTE) begin
      result <= op_value;
    end
  end

endmodule

// File: design/bus_master.sv
`timescale 1ns/1ps

module bus_master import core_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  state_t  state,
  input  addr_t   cmd_ptr,
  input  addr_t   base_addr_data,
  input  data_t   result,
  output addr_t   addr_out,
  output data_t   data_out,
  input  data_t   data_in,
  output logic    read_q,
  output logic    write_q,
  input  logic    read_dn,
  input  logic    write_dn,
  output logic    step_done,
  output cmd_t    command,
  output opcode_t opcode,
  output addr_t   jump_offset,
  output data_t   src0,
  output data_t   src1
);

  logic  half;
  logic  need_read;
  logic  need_write;
  data_t cmd_hi;
  addr_t dst_off;
  addr_t s1_off;
  addr_t s0_off;

  assign need_read  = (state == ST_FETCH) || (state == ST_LOAD_S0) || (state == ST_LOAD_S1);
  assign need_write = (state == ST_STORE);
  assign step_done  = (read_q && read_dn) || (write_q && write_dn);

  assign opcode      = opcode_t'(command[CMD_OP_HI:CMD_OP_LO]);
  assign dst_off     = command[CMD_DST_LO +: ADDR_W];
  assign s1_off      = command[CMD_S1_LO +: ADDR_W];
  assign s0_off      = command[CMD_S0_LO +: ADDR_W];
  assign jump_offset = dst_off;

  // state, pointer and fields do not move while a request is pending
  always_comb begin
    case (state)
      ST_FETCH:   addr_out = cmd_ptr + addr_t'(half);
      ST_LOAD_S0: addr_out = base_addr_data + s0_off;
      ST_LOAD_S1: addr_out = base_addr_data + s1_off;
      ST_STORE:   addr_out = base_addr_data + dst_off;
      default:    addr_out = cmd_ptr;
    endcase
  end

  assign data_out = need_write ? result : '0;

  // request drops after its done pulse and may rise again one cycle later
  always_ff @(posedge clk) begin
    if (rst) begin
      read_q  <= 1'b0;
      write_q <= 1'b0;
      half    <= 1'b0;
    end else if (read_q) begin
      if (read_dn) begin
        read_q <= 1'b0;
        if (state == ST_FETCH) begin
          half <= ~half;
        end
      end
    end else if (write_q) begin
      if (write_dn) begin
        write_q <= 1'b0;
      end
    end else begin
      read_q  <= need_read;
      write_q <= need_write;
    end
  end

  // high half arrives first and the whole command updates with the low half
  always_ff @(posedge clk) begin
    if (read_q && read_dn) begin
      case (state)
        ST_FETCH: begin
          if (half) begin
            command <= {cmd_hi, data_in};
          end else begin
            cmd_hi <= data_in;
          end
        end
        ST_LOAD_S0: src0 <= data_in;
        ST_LOAD_S1: src1 <= data_in;
        default: ;
      endcase
    end
  end

  a_dn_with_req: assert property (
    @(posedge clk) disable iff (rst)
    (!read_dn || read_q) && (!write_dn || write_q)
  ) else $error("bus_master: done pulse without a pending request");

  a_req_hold: assert property (
    @(posedge clk) disable iff (rst)
    ((read_q && !read_dn) || (write_q && !write_dn)) |=>
      ((read_q || write_q) && $stable(addr_out))
  ) else $error("bus_master: request dropped or address moved before done");

endmodule

// File: design/cmd_pointer.sv
`timescale 1ns/1ps

module cmd_pointer import core_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  start,
  input  addr_t base_addr,
  input  logic  ptr_inc,
  input  logic  ptr_jump,
  input  addr_t jump_offset,
  output addr_t cmd_ptr
);

  // each command takes two memory words
  localparam addr_t CMD_STEP = addr_t'(2);

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_ptr <= '0;
    end else if (start) begin
      cmd_ptr <= base_addr;
    end else if (ptr_jump) begin
      // jump target is relative to the program base
      cmd_ptr <= base_addr + jump_offset;
    end else if (ptr_inc) begin
      cmd_ptr <= cmd_ptr + CMD_STEP;
    end
  end

  // fetch end and decode of a jump fall in different states of the sequencer
  a_inc_jump_excl: assert property (
    @(posedge clk) disable iff (rst)
    !(ptr_inc && ptr_jump)
  ) else $error("cmd_pointer: ptr_inc and ptr_jump high together");

endmodule

// File: design/core_pkg.sv
package core_pkg;

  // word widths fixed by the command format
  localparam int ADDR_W = 8;
  localparam int DATA_W = 16;
  localparam int CMD_W  = 32;

  // command field positions
  localparam int CMD_OP_HI  = 31;
  localparam int CMD_OP_LO  = 28;
  localparam int CMD_DST_LO = 16;
  localparam int CMD_S1_LO  = 8;
  localparam int CMD_S0_LO  = 0;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [CMD_W-1:0]  cmd_t;

  // codes not listed here are treated as no-operation
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_MOV  = 4'd5,
    OP_JMP  = 4'd6,
    OP_HALT = 4'd15
  } opcode_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_DECODE,
    ST_LOAD_S0,
    ST_LOAD_S1,
    ST_EXECUTE,
    ST_STORE,
    ST_HALTED
  } state_t;

endpackage

// File: design/internal_bus.sv
`timescale 1ns/1ps

module internal_bus import core_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  start,
  input  addr_t base_addr,
  input  addr_t base_addr_data,
  output addr_t addr_out,
  output data_t data_out,
  input  data_t data_in,
  output logic  read_q,
  output logic  write_q,
  input  logic  read_dn,
  input  logic  write_dn,
  output cmd_t  command,
  output logic  halted
);

  state_t  state;
  opcode_t opcode;
  addr_t   cmd_ptr;
  addr_t   jump_offset;
  data_t   src0;
  data_t   src1;
  data_t   result;
  logic    step_done;
  logic    ptr_inc;
  logic    ptr_jump;

  state_sequencer i_seq (
    .clk(clk),
    .rst(rst),
    .start(start),
    .step_done(step_done),
    .opcode(opcode),
    .state(state),
    .ptr_inc(ptr_inc),
    .ptr_jump(ptr_jump),
    .halted(halted)
  );

  cmd_pointer i_ptr (
    .clk(clk),
    .rst(rst),
    .start(start),
    .base_addr(base_addr),
    .ptr_inc(ptr_inc),
    .ptr_jump(ptr_jump),
    .jump_offset(jump_offset),
    .cmd_ptr(cmd_ptr)
  );

  bus_master i_bus (
    .clk(clk),
    .rst(rst),
    .state(state),
    .cmd_ptr(cmd_ptr),
    .base_addr_data(base_addr_data),
    .result(result),
    .addr_out(addr_out),
    .data_out(data_out),
    .data_in(data_in),
    .read_q(read_q),
    .write_q(write_q),
    .read_dn(read_dn),
    .write_dn(write_dn),
    .step_done(step_done),
    .command(command),
    .opcode(opcode),
    .jump_offset(jump_offset),
    .src0(src0),
    .src1(src1)
  );

  alu i_alu (
    .clk(clk),
    .rst(rst),
    .state(state),
    .opcode(opcode),
    .src0(src0),
    .src1(src1),
    .result(result)
  );

endmodule

// File: design/state_sequencer.sv
`timescale 1ns/1ps

module state_sequencer import core_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    start,
  input  logic    step_done,
  input  opcode_t opcode,
  output state_t  state,
  output logic    ptr_inc,
  output logic    ptr_jump,
  output logic    halted
);

  // set after the first half of a command has arrived
  logic fetch_half;

  assign ptr_inc  = (state == ST_FETCH) && step_done && fetch_half;
  assign ptr_jump = (state == ST_DECODE) && (opcode == OP_JMP);
  assign halted   = (state == ST_HALTED);

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_IDLE;
      fetch_half <= 1'b0;
    end else begin
      case (state)
        ST_IDLE, ST_HALTED: begin
          if (start) begin
            state <= ST_FETCH;
          end
        end
        ST_FETCH: begin
          if (step_done) begin
            fetch_half <= ~fetch_half;
            if (fetch_half) begin
              state <= ST_DECODE;
            end
          end
        end
        ST_DECODE: begin
          case (opcode)
            OP_HALT: state <= ST_HALTED;
            OP_JMP:  state <= ST_FETCH;
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_MOV: begin
              state <= ST_LOAD_S0;
            end
            // unknown code skips to the next command
            default: state <= ST_FETCH;
          endcase
        end
        ST_LOAD_S0: begin
          if (step_done) begin
            // mov needs only one operand
            state <= (opcode == OP_MOV) ? ST_EXECUTE : ST_LOAD_S1;
          end
        end
        ST_LOAD_S1: begin
          if (step_done) begin
            state <= ST_EXECUTE;
          end
        end
        ST_EXECUTE: begin
          state <= ST_STORE;
        end
        ST_STORE: begin
          if (step_done) begin
            state <= ST_FETCH;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // a memory access can only finish in a state that started one
  a_step_in_access: assert property (
    @(posedge clk) disable iff (rst)
    step_done |-> (state inside {ST_FETCH, ST_LOAD_S0, ST_LOAD_S1, ST_STORE})
  ) else $error("state_sequencer: step_done in state %0h", state);

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and scan the log

rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f build.f \
  --top-module tb_internal_bus -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation step failed"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
